/* include/elem_consts.svh */
// Drive element constants
`ifndef ELEM_CONSTS_SVH
`define ELEM_CONSTS_SVH

// table address widths
`define ENV_AW 8 // envelope table, 256 entries
`define CAR_AW 8 // carrier table, top bits of the phase

// phase accumulator, frequency step and initial phase
`define PHASE_W 16

// one signed I or Q component, also the amplitude
`define SAMPLE_W 16

// pipeline depths in clock cycles
`define RAM_LAT 2 // registered address plus registered data
`define MOD_LAT 3 // products, complex sum, amplitude scale

`endif

/* hdl/elem_pkg.sv */
// Drive element types
`include "elem_consts.svh"

package elem_pkg;

	// one complex sample, x is the real part in the upper half
	typedef struct packed {
		logic signed [`SAMPLE_W-1:0] x;
		logic signed [`SAMPLE_W-1:0] y;
	} iq_t;

	// table word: written raw, read back as an x/y pair by the modulator
	typedef union packed {
		logic [2*`SAMPLE_W-1:0] raw;
		iq_t iq;
	} sample_word_u;

endpackage

/* hdl/env_sequencer.sv */
// Envelope and carrier sequencer
`include "elem_consts.svh"

module env_sequencer (
	input  logic elem,
	input  logic rst_n,
	input  logic cmd_stb,
	input  logic [`ENV_AW-1:0] env_start,
	input  logic [`ENV_AW-1:0] env_length,
	input  logic signed [`SAMPLE_W-1:0] amp,
	input  logic [`PHASE_W-1:0] freq_step,
	input  logic [`PHASE_W-1:0] phase_init,
	output logic [`ENV_AW-1:0] env_addr,
	output logic [`CAR_AW-1:0] car_addr,
	output logic sample_gate,
	output logic signed [`SAMPLE_W-1:0] amp_hold,
	output logic busy
);

	logic accept;
	logic [`ENV_AW-1:0] remaining; // samples still to issue
	logic [`ENV_AW-1:0] next_addr;
	logic [`PHASE_W-1:0] next_phase;
	logic [`PHASE_W-1:0] phase;
	logic [`PHASE_W-1:0] step_lat;
	logic signed [`SAMPLE_W-1:0] amp_lat;

	// a strobe counts only when idle and with a non-zero length
	assign accept = cmd_stb && !busy && (env_length != '0);

	always_ff @(posedge elem) begin
		if (!rst_n) begin
			busy <= 1'b0;
			sample_gate <= 1'b0;
			remaining <= '0;
			next_addr <= '0;
			next_phase <= '0;
			env_addr <= '0;
			phase <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			remaining <= env_length;
			next_addr <= env_start;
			next_phase <= phase_init;
		end else if (busy) begin
			if (remaining != '0) begin
				sample_gate <= 1'b1;
				env_addr <= next_addr;
				phase <= next_phase;
				next_addr <= next_addr + 1'b1; // wraps past the table end
				next_phase <= next_phase + step_lat;
				remaining <= remaining - 1'b1;
			end else begin
				// last address went out on the previous cycle
				sample_gate <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	// command fields that are only needed while the burst runs
	always_ff @(posedge elem) begin
		if (accept) begin
			step_lat <= freq_step;
			amp_lat <= amp;
		end
	end

	// amplitude follows the issued addresses, so it changes only when
	// the next burst puts out its first sample
	always_ff @(posedge elem) begin
		if (busy && remaining != '0)
			amp_hold <= amp_lat;
	end

	assign car_addr = phase[`PHASE_W-1 -: `CAR_AW]; // coarse phase indexes the cos/sin table

endmodule

/* hdl/sample_ram.sv */
// Sample table with registered read
`include "elem_consts.svh"

module sample_ram
	import elem_pkg::*;
#(
	parameter int ADDR_W = `ENV_AW
) (
	input  logic elem,
	input  logic rst_n,
	input  logic wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  sample_word_u wr_data,
	input  logic [ADDR_W-1:0] rd_addr,
	input  logic gate,
	output sample_word_u rd_data,
	output logic rd_gate
);

	logic [2*`SAMPLE_W-1:0] mem [0:(2**ADDR_W)-1];
	logic [ADDR_W-1:0] addr_q;
	logic [`RAM_LAT-1:0] gate_sr; // gate follows the read stages

	// load port
	always_ff @(posedge elem) begin
		if (wr_en)
			mem[wr_addr] <= wr_data.raw;
	end

	// read runs every cycle, address then data
	always_ff @(posedge elem) begin
		addr_q <= rd_addr;
		rd_data.raw <= mem[addr_q];
	end

	always_ff @(posedge elem) begin
		if (!rst_n)
			gate_sr <= '0;
		else
			gate_sr <= {gate_sr[`RAM_LAT-2:0], gate};
	end

	assign rd_gate = gate_sr[`RAM_LAT-1];

endmodule

/* hdl/am_modulator.sv */
// Complex amplitude modulator
`include "elem_consts.svh"

module am_modulator
	import elem_pkg::*;
(
	input  logic elem,
	input  logic rst_n,
	input  logic gate,
	input  sample_word_u env,
	input  sample_word_u car,
	input  logic signed [`SAMPLE_W-1:0] amp,
	output logic out_valid,
	output iq_t out_iq
);

	localparam int FRAC = `SAMPLE_W - 1; // Q1.15 scaling
	localparam int PW = 2 * `SAMPLE_W;

	logic [`MOD_LAT-1:0] gate_sr;

	// stage 1
	logic signed [PW-1:0] p_xx;
	logic signed [PW-1:0] p_yy;
	logic signed [PW-1:0] p_xy;
	logic signed [PW-1:0] p_yx;
	logic signed [`SAMPLE_W-1:0] amp_s1;

	// stage 2
	logic signed [PW:0] re_full; // one guard bit for full-scale sums
	logic signed [PW:0] im_full;
	logic signed [`SAMPLE_W-1:0] re_q;
	logic signed [`SAMPLE_W-1:0] im_q;
	logic signed [`SAMPLE_W-1:0] amp_s2;

	// stage 3
	logic signed [PW-1:0] scl_x;
	logic signed [PW-1:0] scl_y;

	// four partial products of env * carrier
	always_ff @(posedge elem) begin
		p_xx <= env.iq.x * car.iq.x;
		p_yy <= env.iq.y * car.iq.y;
		p_xy <= env.iq.x * car.iq.y;
		p_yx <= env.iq.y * car.iq.x;
		amp_s1 <= amp; // amplitude rides along with its own samples
	end

	assign re_full = p_xx - p_yy;
	assign im_full = p_xy + p_yx;

	// arithmetic shift by 15, low 16 bits kept and allowed to wrap
	always_ff @(posedge elem) begin
		re_q <= re_full[FRAC +: `SAMPLE_W];
		im_q <= im_full[FRAC +: `SAMPLE_W];
		amp_s2 <= amp_s1;
	end

	assign scl_x = re_q * amp_s2;
	assign scl_y = im_q * amp_s2;

	// output holds its last sample between bursts
	always_ff @(posedge elem) begin
		if (!rst_n) begin
			out_iq <= '0;
		end else if (gate_sr[`MOD_LAT-2]) begin
			out_iq.x <= scl_x[FRAC +: `SAMPLE_W];
			out_iq.y <= scl_y[FRAC +: `SAMPLE_W];
		end
	end

	always_ff @(posedge elem) begin
		if (!rst_n)
			gate_sr <= '0;
		else
			gate_sr <= {gate_sr[`MOD_LAT-2:0], gate};
	end

	assign out_valid = gate_sr[`MOD_LAT-1];

endmodule

/* hdl/drive_element.sv */
// Qubit drive element top
`include "elem_consts.svh"

module drive_element
	import elem_pkg::*;
(
	input  logic elem,
	input  logic rst_n,
	// command
	input  logic cmd_stb,
	input  logic [`ENV_AW-1:0] env_start,
	input  logic [`ENV_AW-1:0] env_length,
	input  logic signed [`SAMPLE_W-1:0] amp,
	input  logic [`PHASE_W-1:0] freq_step,
	input  logic [`PHASE_W-1:0] phase_init,
	// table loading
	input  logic env_wr_en,
	input  logic [`ENV_AW-1:0] env_wr_addr,
	input  sample_word_u env_wr_data,
	input  logic car_wr_en,
	input  logic [`CAR_AW-1:0] car_wr_addr,
	input  sample_word_u car_wr_data,
	// status and samples
	output logic busy,
	output logic out_valid,
	output iq_t out_iq
);

	logic [`ENV_AW-1:0] env_addr;
	logic [`CAR_AW-1:0] car_addr;
	logic sample_gate;
	logic signed [`SAMPLE_W-1:0] amp_hold;
	sample_word_u env_data;
	sample_word_u car_data;
	logic env_gate; // sample_gate after the table read

	env_sequencer seq0 (
		.elem(elem), .rst_n(rst_n), .cmd_stb(cmd_stb),
		.env_start(env_start), .env_length(env_length), .amp(amp),
		.freq_step(freq_step), .phase_init(phase_init),
		.env_addr(env_addr), .car_addr(car_addr), .sample_gate(sample_gate),
		.amp_hold(amp_hold), .busy(busy)
	);

	sample_ram #(.ADDR_W(`ENV_AW)) env_ram (
		.elem(elem), .rst_n(rst_n), .wr_en(env_wr_en), .wr_addr(env_wr_addr),
		.wr_data(env_wr_data), .rd_addr(env_addr), .gate(sample_gate),
		.rd_data(env_data), .rd_gate(env_gate)
	);

	// same latency as env_ram, its gate copy is not needed
	sample_ram #(.ADDR_W(`CAR_AW)) car_ram (
		.elem(elem), .rst_n(rst_n), .wr_en(car_wr_en), .wr_addr(car_wr_addr),
		.wr_data(car_wr_data), .rd_addr(car_addr), .gate(sample_gate),
		.rd_data(car_data), .rd_gate()
	);

	am_modulator mod0 (
		.elem(elem), .rst_n(rst_n), .gate(env_gate), .env(env_data),
		.car(car_data), .amp(amp_hold), .out_valid(out_valid), .out_iq(out_iq)
	);

endmodule

/* sim/drive_element_assertions.sv */
// Drive element protocol assertions
`include "elem_consts.svh"

module drive_element_assertions (
	input logic elem,
	input logic rst_n,
	input logic cmd_stb,
	input logic [`ENV_AW-1:0] env_length,
	input logic busy,
	input logic out_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic accept;
	logic [`ENV_AW-1:0] len_q [0:3]; // lengths of bursts in flight
	logic [1:0] wp;
	logic [1:0] rp;
	logic [`ENV_AW:0] run; // valid cycles so far in this burst

	assign accept = cmd_stb && !busy && (env_length != '0);

	always_ff @(posedge elem) begin
		if (!rst_n) begin
			wp <= '0;
			rp <= '0;
			run <= '0;
		end else begin
			if (accept) begin
				len_q[wp] <= env_length;
				wp <= wp + 1'b1;
			end
			run <= out_valid ? run + 1'b1 : '0;
			if (!out_valid && run != '0)
				rp <= rp + 1'b1; // burst ended
		end
	end

	// output register updates at edge 6, seen one edge later
	first_sample: assert property (@(posedge elem) disable iff (!rst_n)
		accept |-> ##(1 + `RAM_LAT + `MOD_LAT + 1) $rose(out_valid))
		else $error("out_valid did not rise 6 cycles after an accepted command");

	idle_after_reset: assert property (@(posedge elem) $rose(rst_n) |-> !busy)
		else $error("busy high after reset");

	burst_length: assert property (@(posedge elem) disable iff (!rst_n)
		out_valid |-> (run < {1'b0, len_q[rp]}))
		else $error("out_valid longer than the accepted length");

endmodule

bind drive_element drive_element_assertions asrt0 (.*);

/* sim/drive_element_tb.sv */
// Drive element testbench
`include "elem_consts.svh"

module drive_element_tb
	import elem_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [`ENV_AW-1:0] start;
		logic [`ENV_AW-1:0] len;
		logic signed [`SAMPLE_W-1:0] amp;
		logic [`PHASE_W-1:0] step;
		logic [`PHASE_W-1:0] phase;
	} cmd_t;

	logic elem = 1'b0;
	logic rst_n;
	logic cmd_stb;
	logic [`ENV_AW-1:0] env_start;
	logic [`ENV_AW-1:0] env_length;
	logic signed [`SAMPLE_W-1:0] amp;
	logic [`PHASE_W-1:0] freq_step;
	logic [`PHASE_W-1:0] phase_init;
	logic env_wr_en;
	logic [`ENV_AW-1:0] env_wr_addr;
	sample_word_u env_wr_data;
	logic car_wr_en;
	logic [`CAR_AW-1:0] car_wr_addr;
	sample_word_u car_wr_data;
	logic busy;
	logic out_valid;
	iq_t out_iq;

	logic [2*`SAMPLE_W-1:0] env_mirror [0:(2**`ENV_AW)-1];
	logic [2*`SAMPLE_W-1:0] car_mirror [0:(2**`CAR_AW)-1];
	iq_t exp_q[$];
	logic [`ENV_AW-1:0] len_q[$];
	time t0_q[$]; // edge that sampled each accepted strobe
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int run = 0;
	longint wd_cycles = 0;

	drive_element dut0 (
		.elem(elem), .rst_n(rst_n), .cmd_stb(cmd_stb), .env_start(env_start),
		.env_length(env_length), .amp(amp), .freq_step(freq_step),
		.phase_init(phase_init), .env_wr_en(env_wr_en), .env_wr_addr(env_wr_addr),
		.env_wr_data(env_wr_data), .car_wr_en(car_wr_en), .car_wr_addr(car_wr_addr),
		.car_wr_data(car_wr_data), .busy(busy), .out_valid(out_valid), .out_iq(out_iq)
	);

	always #10 elem = ~elem;

	// expected sample k of a burst by Q1.15 complex multiply and amplitude scale
	function automatic iq_t ref_sample(input int k, input cmd_t c,
			input logic [31:0] em [0:255], input logic [31:0] cm [0:255]);
		logic [`ENV_AW-1:0] ea;
		logic [`PHASE_W-1:0] ph;
		iq_t e;
		iq_t cr;
		iq_t r;
		longint re;
		longint im;
		logic signed [15:0] re16;
		logic signed [15:0] im16;
		longint sx;
		longint sy;
		ea = c.start + 8'(k); // wraps past 255
		ph = c.phase + 16'(k) * c.step;
		e = em[ea];
		cr = cm[ph[15:8]];
		re = longint'(e.x) * longint'(cr.x) - longint'(e.y) * longint'(cr.y);
		im = longint'(e.x) * longint'(cr.y) + longint'(e.y) * longint'(cr.x);
		re = re >>> 15;
		im = im >>> 15;
		re16 = re[15:0];
		im16 = im[15:0];
		sx = (longint'(re16) * longint'(c.amp)) >>> 15;
		sy = (longint'(im16) * longint'(c.amp)) >>> 15;
		r.x = sx[15:0];
		r.y = sy[15:0];
		return r;
	endfunction

	task automatic check_iq(input iq_t exp_v, input iq_t got);
		checks++;
		if (got !== exp_v) begin
			errors++;
			$display("mismatch out_iq: expected %h got %h", exp_v, got);
		end
	endtask

	task automatic check_count(input logic [`ENV_AW-1:0] exp_len, input int got);
		checks++;
		if (got < int'(exp_len)) begin
			errors++;
			$display("burst ended after %0d samples, %0d were missing", got, int'(exp_len) - got);
		end else if (got > int'(exp_len)) begin
			errors++;
			$display("burst gave %0d extra samples beyond %0d", got - int'(exp_len), exp_len);
		end
	endtask

	// comparator sees outputs as registered by the previous edge
	always @(posedge elem) begin : compare_proc
		time lat;
		if (rst_n) begin
			if (out_valid) begin
				if (run == 0 && t0_q.size() != 0) begin
					lat = ($time - t0_q.pop_front()) / 20;
					checks++;
					if (lat != time'(1 + `RAM_LAT + `MOD_LAT + 1)) begin
						errors++;
						$display("first sample came %0d cycles after the strobe", lat - 1);
					end
				end
				run++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("out_valid with no sample expected");
				end else begin
					check_iq(exp_q.pop_front(), out_iq);
				end
			end else if (run != 0) begin
				if (len_q.size() == 0) begin
					errors++;
					$display("a burst came out that no command asked for");
				end else begin
					check_count(len_q.pop_front(), run);
				end
				run = 0;
			end
		end
	end

	task automatic write_word(input bit to_car, input logic [7:0] addr, input logic [31:0] w);
		@(posedge elem);
		if (to_car) begin
			car_wr_en <= 1'b1;
			car_wr_addr <= addr;
			car_wr_data.raw <= w;
			car_mirror[addr] = w;
		end else begin
			env_wr_en <= 1'b1;
			env_wr_addr <= addr;
			env_wr_data.raw <= w;
			env_mirror[addr] = w;
		end
		@(posedge elem);
		env_wr_en <= 1'b0;
		car_wr_en <= 1'b0;
	endtask

	task automatic issue(input cmd_t c, input bit accepted);
		@(posedge elem);
		cmd_stb <= 1'b1;
		env_start <= c.start;
		env_length <= c.len;
		amp <= c.amp;
		freq_step <= c.step;
		phase_init <= c.phase;
		@(posedge elem); // edge 0
		cmd_stb <= 1'b0;
		if (accepted) begin
			for (int k = 0; k < int'(c.len); k++)
				exp_q.push_back(ref_sample(k, c, env_mirror, car_mirror));
			len_q.push_back(c.len);
			t0_q.push_back($time);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || busy)
			@(posedge elem);
		repeat (8) @(posedge elem);
		if (len_q.size() != 0) begin
			errors++;
			$display("%0d bursts never finished", len_q.size());
			len_q.delete();
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "failed");
	endtask

	function automatic cmd_t rand_cmd(input int max_len);
		cmd_t c;
		c.start = 8'($urandom);
		c.len = 8'(1 + $urandom % max_len);
		c.amp = 16'($urandom);
		c.step = 16'($urandom);
		c.phase = 16'($urandom);
		return c;
	endfunction

	initial begin : watchdog
		wait (wd_cycles != 0);
		#(wd_cycles * 20);
		$display("watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : main
		cmd_t c2;
		cmd_t c3;
		cmd_t ca;
		cmd_t cb;
		cmd_t c5 [0:2];
		cmd_t c6;
		int e0;
		rst_n = 1'b0;
		cmd_stb = 1'b0;
		env_start = '0;
		env_length = '0;
		amp = '0;
		freq_step = '0;
		phase_init = '0;
		env_wr_en = 1'b0;
		env_wr_addr = '0;
		env_wr_data = '0;
		car_wr_en = 1'b0;
		car_wr_addr = '0;
		car_wr_data = '0;
		void'($urandom(32'hda37_8a16));

		c2 = rand_cmd(60);
		c3 = '{start: 8'd250, len: 8'd12, amp: 16'sh4000, step: 16'h0400, phase: 16'hf000};
		ca = rand_cmd(1);
		ca.len = 8'd20;
		cb = rand_cmd(1);
		cb.len = 8'd5;
		for (int i = 0; i < 3; i++)
			c5[i] = rand_cmd(40);
		c6 = '{start: 8'd100, len: 8'd4, amp: 16'sh8000, step: 16'h0000, phase: 16'h4000};
		// two tables of 256 words at two cycles per word, plus one test's margin
		wd_cycles = 4 * 256 + 40 + 40 * 6 + c2.len + c3.len + ca.len + cb.len
			+ c5[0].len + c5[1].len + c5[2].len + c6.len;

		repeat (2) @(posedge elem);
		rst_n <= 1'b1;
		@(posedge elem);

		// test 1 looks at the reset state
		e0 = errors;
		@(posedge elem);
		checks += 2;
		if (busy !== 1'b0 || out_valid !== 1'b0) begin
			errors++;
			$display("busy or out_valid not low after reset");
		end
		check_iq(iq_t'(0), out_iq);
		end_test("reset", e0);

		for (int i = 0; i < 256; i++) begin
			write_word(1'b0, 8'(i), $urandom);
			write_word(1'b1, 8'(i), $urandom);
		end

		// test 2 runs one random burst
		e0 = errors;
		issue(c2, 1'b1);
		wait_drain();
		end_test("single burst", e0);

		// test 3 wraps address and phase
		e0 = errors;
		issue(c3, 1'b1);
		wait_drain();
		end_test("wrap", e0);

		// test 4 strobes while busy and then with a zero length
		e0 = errors;
		issue(ca, 1'b1);
		repeat (3) @(posedge elem);
		issue(cb, 1'b0);
		wait_drain();
		cb.len = 8'd0;
		issue(cb, 1'b0);
		@(posedge elem);
		checks++;
		if (busy !== 1'b0) begin
			errors++;
			$display("busy rose for a zero length command");
		end
		repeat (20) @(posedge elem);
		end_test("ignored commands", e0);

		// next strobe sampled on the first edge with busy low
		e0 = errors;
		for (int i = 0; i < 3; i++) begin
			issue(c5[i], 1'b1);
			if (i < 2)
				repeat (int'(c5[i].len)) @(posedge elem);
		end
		wait_drain();
		end_test("back to back", e0);

		// full-scale words with amplitude -1.0
		e0 = errors;
		write_word(1'b0, 8'd100, 32'h8000_8000);
		write_word(1'b0, 8'd101, 32'h7fff_8000);
		write_word(1'b0, 8'd102, 32'h8000_7fff);
		write_word(1'b0, 8'd103, 32'h7fff_7fff);
		write_word(1'b1, 8'h40, 32'h8000_7fff);
		issue(c6, 1'b1);
		wait_drain();
		end_test("full scale", e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* drive_element.f */
+incdir+include
hdl/elem_pkg.sv
hdl/env_sequencer.sv
hdl/sample_ram.sv
hdl/am_modulator.sv
hdl/drive_element.sv
sim/drive_element_assertions.sv
sim/drive_element_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the drive element testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module drive_element_tb \
	-f drive_element.f

./obj_dir/Vdrive_element_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi
